// ==== dbus_settings.svh ====
// Architectural constants for the data-bus section
// Widths are fixed by the 36-bit word and are not meant to be changed
// Bit numbering is big-endian throughout, bit 0 most significant
// Microcode addresses are octal, 12 bits wide
`ifndef DBUS_SETTINGS_SVH
`define DBUS_SETTINGS_SVH

////////////////////
// Word geometry
////////////////////

// Full data word
`define WORD_WIDTH 36

// Ramfile holds ACs and cached words
`define RAM_DEPTH 1024
`define RAM_ADDR_WIDTH 10

////////////////////
// Force-ramfile exclusions
////////////////////

// AC references here must see memory data, not the ramfile
`define NOFORCE_ADDR_A 12'o1146
`define NOFORCE_ADDR_B 12'o3666

// Constant bits between interrupt priority and VMA in the flags word
`define FLAGS_FILLER 4'b1111

`endif

// ==== dbus_pkg.sv ====
// Types shared by the data-bus RTL and its testbench
// Bit 0 is the most significant bit of every vector type
// microWord_t field order is fixed, a testbench packing it must match
`default_nettype none

`include "dbus_settings.svh"

package dbus_pkg;

   ////////////////////
   // Data words
   ////////////////////

   typedef logic [0:`WORD_WIDTH-1]   word_t;
   typedef logic [0:`WORD_WIDTH/2-1] halfWord_t;

   // VMA keeps the original bit numbers 14 to 35
   typedef logic [14:`WORD_WIDTH-1]  vmaAddr_t;

   // Cycle-type flags, loaded from dp bits 0 to 13
   typedef struct packed {
      logic       readCycle;
      logic       writeCycle;
      logic       physical;
      logic       user;
      logic       fetch;
      logic [0:8] spare;
   } vmaFlags_t;

   ////////////////////
   // Microword fields
   ////////////////////

   typedef enum logic [1:0] {DBUS_FLAGS, DBUS_DP, DBUS_RAMFILE, DBUS_DBM} dbusSel_t;
   typedef enum logic [1:0] {DBM_MEM, DBM_DPSWAP, DBM_VMA, DBM_NUMBER} dbmSel_t;

   // AC uses VMA low bits, NUMBER uses the microword constant
   typedef enum logic {RAM_AC, RAM_NUMBER} ramAddrSel_t;

   typedef struct packed {
      logic [0:11] jump;       // current microcode address
      dbusSel_t    dbusSel;
      dbmSel_t     dbmSel;
      ramAddrSel_t ramAddrSel;
      logic        ramWrite;
      logic        loadVma;
      halfWord_t   number;
   } microWord_t;

endpackage

`default_nettype wire

// ==== vmaRegister.sv ====
// Virtual memory address and flags register
// Loads from the datapath only when the microword asks for it
// acRef reads 1 after reset, harmless since readCycle is then 0
`timescale 1ns/1ns
`default_nettype none

module vmaRegister (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    loadVma,
   input  wire dbus_pkg::word_t   dp,
   output dbus_pkg::vmaAddr_t     vmaAddr,
   output dbus_pkg::vmaFlags_t    vmaFlags,
   output logic                   acRef
);

   import dbus_pkg::*;

   ////////////////////
   // Register
   ////////////////////

   // Flags in dp 0..13, address in dp 14..35
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vmaAddr  <= '0;
         vmaFlags <= '0;
      end
      else if (loadVma)
      begin
         vmaFlags <= vmaFlags_t'(dp[0:13]);
         vmaAddr  <= dp[14:35];
      end
   end

   ////////////////////
   // AC reference decode
   ////////////////////

   // Lowest sixteen words of the address space
   // Only bits 32..35 may be set for an AC
   // ACs are never reached by a physical reference
   always_comb
   begin
      acRef = ~vmaFlags.physical & (vmaAddr[18:31] == 14'b0);
   end

   // Bits 14..17 are section bits and play no part in the decode
   // User and fetch flags ride along unchanged

endmodule

`default_nettype wire

// ==== ramfile.sv ====
// 1024 x 36 ramfile for ACs and cached words
// Asynchronous read, write on the rising clock edge
// A read in the write cycle returns the old contents
// The array has no reset, contents are undefined until written
`timescale 1ns/1ns
`default_nettype none

`include "dbus_settings.svh"

module ramfile (
   input  wire                         clk,
   input  wire dbus_pkg::ramAddrSel_t  ramAddrSel,
   input  wire dbus_pkg::halfWord_t    number,
   input  wire dbus_pkg::vmaAddr_t     vmaAddr,
   input  wire                         ramWrite,
   input  wire dbus_pkg::word_t        dbus,
   output dbus_pkg::word_t             ramData
);

   import dbus_pkg::*;

   // Low bit positions of each address source
   localparam int vmaLow = `WORD_WIDTH - `RAM_ADDR_WIDTH;
   localparam int numLow = `WORD_WIDTH / 2 - `RAM_ADDR_WIDTH;

   logic [0:`RAM_ADDR_WIDTH-1] ramAddr;

   // Storage
   word_t mem [0:`RAM_DEPTH-1];

   ////////////////////
   // Address select
   ////////////////////

   // AC case takes VMA bits 26..35
   // Number case takes the low ten bits of the constant
   always_comb
   begin
      if (ramAddrSel == RAM_AC)
      begin
         ramAddr = vmaAddr[vmaLow:`WORD_WIDTH-1];
      end
      else
      begin
         ramAddr = number[numLow:`WORD_WIDTH/2-1];
      end
   end

   ////////////////////
   // Read and write
   ////////////////////

   // Combinational read port
   always_comb
   begin
      ramData = mem[ramAddr];
   end

   // Bus feeds straight back into storage
   always_ff @(posedge clk)
   begin
      if (ramWrite)
      begin
         mem[ramAddr] <= dbus;
      end
   end

   // Same address drives both ports,
   // so a write lands where the read was looking

endmodule

`default_nettype wire

// ==== dbmMux.sv ====
// Data-bus-mux, the secondary source select ahead of the bus
// Purely combinational, one microword field picks the source
// Number field appears in both halves of the word
`timescale 1ns/1ns
`default_nettype none

`include "dbus_settings.svh"

module dbmMux (
   input  wire dbus_pkg::dbmSel_t    dbmSel,
   input  wire dbus_pkg::word_t      memData,
   input  wire dbus_pkg::word_t      dp,
   input  wire dbus_pkg::vmaAddr_t   vmaAddr,
   input  wire dbus_pkg::vmaFlags_t  vmaFlags,
   input  wire dbus_pkg::halfWord_t  number,
   output dbus_pkg::word_t           dbm
);

   import dbus_pkg::*;

   // Split point between left and right halves
   localparam int half = `WORD_WIDTH / 2;

   ////////////////////
   // Source select
   ////////////////////

   always_comb
   begin
      case (dbmSel)
         // Main memory read data
         DBM_MEM:
         begin
            dbm = memData;
         end
         // Datapath with halves exchanged
         DBM_DPSWAP:
         begin
            dbm = {dp[half:`WORD_WIDTH-1], dp[0:half-1]};
         end
         // Flags on the left, address on the right
         DBM_VMA:
         begin
            dbm = {vmaFlags, vmaAddr};
         end
         // Microcode constant, duplicated
         DBM_NUMBER:
         begin
            dbm = {number, number};
         end
         default:
         begin
            dbm = memData;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== dbusMux.sv ====
// Data-bus selector with the force-ramfile rule
// Read cycles that hit the cache or an AC take ramfile data,
// except at the two excluded microcode addresses
// Force applies only to the DBM selection
`timescale 1ns/1ns
`default_nettype none

`include "dbus_settings.svh"

module dbusMux (
   input  wire dbus_pkg::microWord_t  crom,
   input  wire                        cacheHit,
   input  wire                        acRef,
   input  wire dbus_pkg::vmaFlags_t   vmaFlags,
   input  wire dbus_pkg::vmaAddr_t    vmaAddr,
   input  wire dbus_pkg::halfWord_t   pcFlags,
   input  wire logic [0:2]            reqIntp,
   input  wire dbus_pkg::word_t       dp,
   input  wire dbus_pkg::word_t       ramData,
   input  wire dbus_pkg::word_t       dbm,
   output dbus_pkg::word_t            dbus
);

   import dbus_pkg::*;

   logic  noForceAddr;
   logic  forceRamfile;
   word_t flagsWord;

   ////////////////////
   // Force ramfile
   ////////////////////

   // Microcode steps that must see memory even on an AC reference
   assign noForceAddr = (crom.jump == `NOFORCE_ADDR_A) |
                        (crom.jump == `NOFORCE_ADDR_B);

   // Cache hit alone is enough, AC needs the address check
   assign forceRamfile = vmaFlags.readCycle &
                         (cacheHit | (acRef & ~noForceAddr));

   ////////////////////
   // Bus select
   ////////////////////

   // PC flags, zero, priority, filler, low ten VMA bits
   assign flagsWord = {pcFlags, 1'b0, reqIntp, `FLAGS_FILLER, vmaAddr[26:35]};

   always_comb
   begin
      case (crom.dbusSel)
         DBUS_FLAGS:
         begin
            dbus = flagsWord;
         end
         DBUS_DP:
         begin
            dbus = dp;
         end
         DBUS_RAMFILE:
         begin
            dbus = ramData;
         end
         // Memory path bypassed when ramfile is forced
         default:
         begin
            dbus = forceRamfile ? ramData : dbm;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== dbusTop.sv ====
// Data-bus section top level
// Bus output loops back as ramfile write data
// Microsequencer, ALU, cache tags and memory sit outside
`timescale 1ns/1ns
`default_nettype none

module dbusTop (
   input  wire                         clk,
   input  wire                         rst,
   input  wire dbus_pkg::microWord_t   crom,
   input  wire dbus_pkg::word_t        dp,
   input  wire dbus_pkg::word_t        memData,
   input  wire                         cacheHit,
   input  wire dbus_pkg::halfWord_t    pcFlags,
   input  wire logic [0:2]             reqIntp,
   output wire dbus_pkg::word_t        dbus,
   output wire dbus_pkg::vmaAddr_t     vmaAddr,
   output wire dbus_pkg::vmaFlags_t    vmaFlags
);

   import dbus_pkg::*;

   wire        acRef;
   wire word_t ramData;
   wire word_t dbm;

   // VMA and AC decode
   vmaRegister i_vmaRegister (
      .clk      (clk),
      .rst      (rst),
      .loadVma  (crom.loadVma),
      .dp       (dp),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .acRef    (acRef)
   );

   // AC and cache storage, written from the bus
   ramfile i_ramfile (
      .clk        (clk),
      .ramAddrSel (crom.ramAddrSel),
      .number     (crom.number),
      .vmaAddr    (vmaAddr),
      .ramWrite   (crom.ramWrite),
      .dbus       (dbus),
      .ramData    (ramData)
   );

   // Secondary source select
   dbmMux i_dbmMux (
      .dbmSel   (crom.dbmSel),
      .memData  (memData),
      .dp       (dp),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .number   (crom.number),
      .dbm      (dbm)
   );

   // Final bus select with ramfile forcing
   dbusMux i_dbusMux (
      .crom     (crom),
      .cacheHit (cacheHit),
      .acRef    (acRef),
      .vmaFlags (vmaFlags),
      .vmaAddr  (vmaAddr),
      .pcFlags  (pcFlags),
      .reqIntp  (reqIntp),
      .dp       (dp),
      .ramData  (ramData),
      .dbm      (dbm),
      .dbus     (dbus)
   );

endmodule

`default_nettype wire

// ==== dbus_assertions.sv ====
// Concurrent checks bound into the data-bus top level
// All checks are idle while rst is high
// failCount is read by the testbench at the end of the run
`timescale 1ns/1ns
`default_nettype none

`include "dbus_settings.svh"

module dbus_assertions (
   input wire                        clk,
   input wire                        rst,
   input wire dbus_pkg::microWord_t  crom,
   input wire                        cacheHit,
   input wire                        acRef,
   input wire dbus_pkg::vmaAddr_t    vmaAddr,
   input wire dbus_pkg::vmaFlags_t   vmaFlags,
   input wire dbus_pkg::word_t       dbus,
   input wire dbus_pkg::word_t       ramData,
   input wire dbus_pkg::word_t       dbm
);

   import dbus_pkg::*;

   int   failCount = 0;
   logic forceOnBus;

   // Force condition as seen on the bus through the DBM select
   assign forceOnBus = (crom.dbusSel == DBUS_DBM) & vmaFlags.readCycle &
                       (cacheHit | (acRef & (crom.jump != `NOFORCE_ADDR_A) &
                                    (crom.jump != `NOFORCE_ADDR_B)));

   ////////////////////
   // Properties
   ////////////////////

   // Forced read cycles carry ramfile data
   forcedBus: assert property (@(posedge clk) disable iff (rst)
      forceOnBus |-> (dbus == ramData))
   else
   begin
      $error("bus does not carry ramfile data on a forced read");
      failCount++;
   end

   // Physical reads never count as AC references
   // Without a cache hit the bus keeps the DBM source
   physicalNoForce: assert property (@(posedge clk) disable iff (rst)
      ((crom.dbusSel == DBUS_DBM) && vmaFlags.readCycle && vmaFlags.physical && !cacheHit)
      |-> (dbus == dbm))
   else
   begin
      $error("physical read forced the ramfile onto the bus");
      failCount++;
   end

   // VMA only moves on a load
   vmaHolds: assert property (@(posedge clk) disable iff (rst)
      !crom.loadVma |=> ($stable(vmaAddr) && $stable(vmaFlags)))
   else
   begin
      $error("VMA changed without a load");
      failCount++;
   end

endmodule

bind dbusTop dbus_assertions i_dbusAssertions (
   .clk      (clk),
   .rst      (rst),
   .crom     (crom),
   .cacheHit (cacheHit),
   .acRef    (acRef),
   .vmaAddr  (vmaAddr),
   .vmaFlags (vmaFlags),
   .dbus     (dbus),
   .ramData  (ramData),
   .dbm      (dbm)
);

`default_nettype wire

// ==== dbus_tb.sv ====
// Self-checking random testbench for the data-bus section
// Inputs change 10 ns after the rising edge, the bus is checked at 50 ns
// A shadow VMA and ramfile predict every bus value
// Ramfile reads are only meaningful after the fill phase
`timescale 1ns/1ns
`default_nettype none

`include "dbus_settings.svh"

module dbus_tb;

   import dbus_pkg::*;

   // Phase lengths in cycles
   localparam int resetCycles    = 8;
   localparam int dpCycles       = 20;
   localparam int flagsCycles    = 100;
   localparam int readbackCycles = 300;
   localparam int dbmCycles      = 200;
   localparam int forceCycles    = 200;
   localparam int noForceCycles  = 204;
   localparam int randomCycles   = 2000;
   localparam int plannedCycles  = resetCycles + dpCycles + flagsCycles + `RAM_DEPTH +
                                   readbackCycles + dbmCycles + forceCycles +
                                   noForceCycles + randomCycles;
   localparam int timeoutLimit   = plannedCycles + 100;

   logic       clk;
   logic       rst;
   microWord_t crom;
   word_t      dp;
   word_t      memData;
   logic       cacheHit;
   halfWord_t  pcFlags;
   logic [0:2] reqIntp;
   word_t      dbus;
   vmaAddr_t   vmaAddr;
   vmaFlags_t  vmaFlags;

   // Reference model state
   vmaAddr_t   shadowAddr;
   vmaFlags_t  shadowFlags;
   word_t      shadowRam [0:`RAM_DEPTH-1];

   int busErrors;
   int vmaErrors;
   int assertFails;
   int cycleCount = 0;

   dbusTop i_dbusTop (
      .clk      (clk),
      .rst      (rst),
      .crom     (crom),
      .dp       (dp),
      .memData  (memData),
      .cacheHit (cacheHit),
      .pcFlags  (pcFlags),
      .reqIntp  (reqIntp),
      .dbus     (dbus),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= timeoutLimit)
      begin
         $display("Timeout: no verdict after %0d cycles", cycleCount);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // Random stimulus
   ////////////////////

   function automatic word_t randWord();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $urandom();
      lo = $urandom();
      return {hi[3:0], lo};
   endfunction

   function automatic halfWord_t randHalf();
      logic [31:0] r;
      r = $urandom();
      return r[17:0];
   endfunction

   function automatic logic randBit();
      logic [31:0] r;
      r = $urandom();
      return r[0];
   endfunction

   function automatic microWord_t randMicroWord();
      microWord_t  mw;
      logic [31:0] r;
      r = $urandom();
      mw.jump       = r[11:0];
      mw.dbusSel    = dbusSel_t'(r[13:12]);
      mw.dbmSel     = dbmSel_t'(r[15:14]);
      mw.ramAddrSel = ramAddrSel_t'(r[16]);
      mw.ramWrite   = r[17];
      mw.loadVma    = r[18];
      mw.number     = randHalf();
      return mw;
   endfunction

   // Any microcode address except the two exclusions
   function automatic logic [0:11] forcingJump();
      logic [31:0] r;
      do
         r = $urandom();
      while (r[11:0] == `NOFORCE_ADDR_A || r[11:0] == `NOFORCE_ADDR_B);
      return r[11:0];
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   function automatic logic [0:9] modelRamAddr(microWord_t mw);
      if (mw.ramAddrSel == RAM_AC)
         return shadowAddr[26:35];
      return mw.number[8:17];
   endfunction

   // Expected bus from the driven inputs and shadow state
   function automatic word_t modelBus();
      word_t ramWord;
      word_t dbmWord;
      logic  acHit;
      logic  forced;
      ramWord = shadowRam[modelRamAddr(crom)];
      acHit   = !shadowFlags.physical && (shadowAddr[18:31] == 14'd0);
      forced  = shadowFlags.readCycle && (cacheHit || (acHit &&
                crom.jump != `NOFORCE_ADDR_A && crom.jump != `NOFORCE_ADDR_B));
      case (crom.dbmSel)
         DBM_MEM:    dbmWord = memData;
         DBM_DPSWAP: dbmWord = {dp[18:35], dp[0:17]};
         DBM_VMA:    dbmWord = {shadowFlags, shadowAddr};
         default:    dbmWord = {crom.number, crom.number};
      endcase
      case (crom.dbusSel)
         DBUS_FLAGS:   return {pcFlags, 1'b0, reqIntp, 4'b1111, shadowAddr[26:35]};
         DBUS_DP:      return dp;
         DBUS_RAMFILE: return ramWord;
         default:      return forced ? ramWord : dbmWord;
      endcase
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic checkWord(input string name, input word_t actual, input word_t expected);
      if (actual !== expected)
      begin
         busErrors++;
         $display("error at %0t ns: %s is %o, expected %o", $time, name, actual, expected);
      end
   endtask

   task automatic checkVma(input vmaAddr_t actAddr, input vmaFlags_t actFlags,
                           input vmaAddr_t expAddr, input vmaFlags_t expFlags);
      if (actAddr !== expAddr)
      begin
         vmaErrors++;
         $display("error at %0t ns: vmaAddr is %o, expected %o", $time, actAddr, expAddr);
      end
      if (actFlags !== expFlags)
      begin
         vmaErrors++;
         $display("error at %0t ns: vmaFlags is %o, expected %o", $time, actFlags, expFlags);
      end
   endtask

   // One microcycle: drive, check mid-cycle, advance the model
   task automatic runCycle(input microWord_t mw, input word_t dpIn, input logic hit);
      logic [31:0] r;
      word_t       expBus;
      @(posedge clk);
      #10;
      r        = $urandom();
      crom     = mw;
      dp       = dpIn;
      cacheHit = hit;
      memData  = randWord();
      pcFlags  = randHalf();
      reqIntp  = r[2:0];
      #40;
      expBus = modelBus();
      checkWord("dbus", dbus, expBus);
      checkVma(vmaAddr, vmaFlags, shadowAddr, shadowFlags);
      // Both land on the coming edge, write uses the old VMA
      if (mw.ramWrite)
         shadowRam[modelRamAddr(mw)] = expBus;
      if (mw.loadVma)
      begin
         shadowFlags = vmaFlags_t'(dpIn[0:13]);
         shadowAddr  = dpIn[14:35];
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      microWord_t mw;
      word_t      w;
      void'($urandom(32'h6a7f_5215));
      rst         = 1'b1;
      crom        = '0;
      dp          = '0;
      memData     = '0;
      cacheHit    = 1'b0;
      pcFlags     = '0;
      reqIntp     = '0;
      shadowAddr  = '0;
      shadowFlags = '0;
      busErrors   = 0;
      vmaErrors   = 0;
      repeat (resetCycles) @(posedge clk);
      #10;
      rst = 1'b0;

      // Reset state and DP pass-through
      checkVma(vmaAddr, vmaFlags, '0, '0);
      for (int i = 0; i < dpCycles; i++)
      begin
         mw          = randMicroWord();
         mw.dbusSel  = DBUS_DP;
         mw.ramWrite = 1'b0;
         mw.loadVma  = 1'b0;
         runCycle(mw, randWord(), randBit());
      end

      // Flags word with a moving VMA
      for (int i = 0; i < flagsCycles; i++)
      begin
         mw          = randMicroWord();
         mw.dbusSel  = DBUS_FLAGS;
         mw.ramWrite = 1'b0;
         runCycle(mw, randWord(), randBit());
      end

      // Fill every location through the number field
      for (int i = 0; i < `RAM_DEPTH; i++)
      begin
         mw                = randMicroWord();
         mw.dbusSel        = DBUS_DP;
         mw.ramAddrSel     = RAM_NUMBER;
         mw.number[8:17]   = i[9:0];
         mw.ramWrite       = 1'b1;
         runCycle(mw, randWord(), randBit());
      end

      // Random readback, AC or number addressed
      for (int i = 0; i < readbackCycles; i++)
      begin
         mw          = randMicroWord();
         mw.dbusSel  = DBUS_RAMFILE;
         mw.ramWrite = 1'b0;
         runCycle(mw, randWord(), randBit());
      end

      // All DBM sources, read flag kept clear
      for (int i = 0; i < dbmCycles; i++)
      begin
         mw          = randMicroWord();
         w           = randWord();
         w[0]        = 1'b0;
         mw.dbusSel  = DBUS_DBM;
         mw.dbmSel   = dbmSel_t'(i[1:0]);
         mw.ramWrite = 1'b0;
         if (i == 0)
            mw.loadVma = 1'b1;
         runCycle(mw, w, randBit());
      end

      // Forced reads, AC groups then cache-hit groups
      for (int i = 0; i < forceCycles; i++)
      begin
         mw          = randMicroWord();
         w           = randWord();
         mw.ramWrite = 1'b0;
         if (i % 4 == 0)
         begin
            w[0] = 1'b1;
            w[2] = 1'b0;
            if (i % 8 == 0)
               w[18:31] = '0;
            mw.dbusSel = DBUS_DP;
            mw.loadVma = 1'b1;
            runCycle(mw, w, 1'b0);
         end
         else
         begin
            mw.dbusSel = DBUS_DBM;
            mw.jump    = forcingJump();
            mw.loadVma = 1'b0;
            runCycle(mw, w, (i % 8 < 4) ? randBit() : 1'b1);
         end
      end

      // Excluded addresses, physical ACs, write cycles with a hit
      for (int i = 0; i < noForceCycles; i++)
      begin
         mw          = randMicroWord();
         w           = randWord();
         mw.ramWrite = 1'b0;
         if (i % 4 == 0)
         begin
            w[18:31]   = '0;
            w[0]       = ((i / 4) % 3 != 2);
            w[1]       = ((i / 4) % 3 == 2);
            w[2]       = ((i / 4) % 3 == 1);
            mw.dbusSel = DBUS_DP;
            mw.loadVma = 1'b1;
            runCycle(mw, w, 1'b0);
         end
         else
         begin
            mw.dbusSel = DBUS_DBM;
            mw.loadVma = 1'b0;
            if ((i / 4) % 3 == 0)
               mw.jump = (i % 2 == 0) ? `NOFORCE_ADDR_A : `NOFORCE_ADDR_B;
            runCycle(mw, w, (i / 4) % 3 == 2);
         end
      end

      // Fully random microwords
      for (int i = 0; i < randomCycles; i++)
      begin
         runCycle(randMicroWord(), randWord(), randBit());
      end

      @(posedge clk);
      #10;
      assertFails = i_dbusTop.i_dbusAssertions.failCount;
      $display("Summary: %0d bus errors, %0d VMA errors, %0d assertion failures",
               busErrors, vmaErrors, assertFails);
      if (busErrors == 0 && vmaErrors == 0 && assertFails == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
dbus_pkg.sv
vmaRegister.sv
ramfile.sv
dbmMux.sv
dbusMux.sv
dbusTop.sv
dbus_assertions.sv
dbus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the data-bus testbench with Verilator and runs it
# Exit status is 0 only when the pass message appears in the output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
      -f project.f --top-module dbus_tb -o Vdbus_tb; then
   echo "Verilator build failed"
   exit 1
fi

if ! simOutput=$(./obj_dir/Vdbus_tb +verilator+error+limit+100000); then
   echo "$simOutput"
   echo "Simulation exited with an error status"
   exit 1
fi

echo "$simOutput"

if echo "$simOutput" | grep -qF '*** TEST PASSED ***'; then
   echo "Result: pass"
   exit 0
fi

echo "Result: fail"
exit 1
